// ==== files.f ====
rtl/mips_pkg.sv
rtl/instruction_fetch.sv
rtl/instruction_decode.sv
rtl/execution.sv
rtl/memory_access.sv
rtl/mips.sv
sim/clock_gen.sv
sim/mips_tb.sv

// ==== rtl/execution.sv ====
`default_nettype none

module execution (
    output mips_pkg::ex_mem_t  o_ex_mem_next ,
    input  mips_pkg::id_ex_t   i_id_ex
);

    mips_pkg::data_t     op_b;          // Second ALU operand
    mips_pkg::data_t     alu_result;
    mips_pkg::reg_addr_t dst;

    assign op_b = i_id_ex.ctrl.alu_src ? i_id_ex.imm : i_id_ex.rb;

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------
    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            mips_pkg::ALU_ADD: alu_result = i_id_ex.ra + op_b;    // Also load/store address
            mips_pkg::ALU_SUB: alu_result = i_id_ex.ra - op_b;
            mips_pkg::ALU_AND: alu_result = i_id_ex.ra & op_b;
            mips_pkg::ALU_OR:  alu_result = i_id_ex.ra | op_b;
            mips_pkg::ALU_SLT: begin
                alu_result = mips_pkg::data_t'($signed(i_id_ex.ra) < $signed(op_b));
            end
            default:           alu_result = '0;
        endcase
    end

    assign dst = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;   // R-type writes rd

    assign o_ex_mem_next = '{ctrl:       i_id_ex.ctrl,
                             alu_result: alu_result,
                             store_data: i_id_ex.rb,
                             dst:        dst};

endmodule

`default_nettype wire

// ==== rtl/instruction_decode.sv ====
`default_nettype none

module instruction_decode (
    output mips_pkg::id_ex_t     o_id_ex_next             ,
    output logic                 o_stall                  ,
    output mips_pkg::data_t      o_debug_read_reg         ,

    input  mips_pkg::if_id_t     i_if_id                  ,
    input  mips_pkg::id_ex_t     i_id_ex                  ,
    input  mips_pkg::data_t      i_ex_result              ,
    input  mips_pkg::ex_mem_t    i_ex_mem                 ,
    input  mips_pkg::data_t      i_mem_result             ,
    input  mips_pkg::mem_wb_t    i_mem_wb                 ,
    input  mips_pkg::reg_addr_t  i_debug_read_reg_address ,
    input  logic                 i_rst_n                  ,
    input  logic                 i_clock
);

    mips_pkg::data_t              reg_file [2**mips_pkg::NB_REG_ADDR];
    logic [mips_pkg::NB_OP-1:0]   op;
    logic [mips_pkg::NB_FUNCT-1:0] funct;
    mips_pkg::reg_addr_t          rs;
    mips_pkg::reg_addr_t          rt;
    mips_pkg::reg_addr_t          rd;
    mips_pkg::reg_addr_t          ex_dst;      // Destination of the entry in EX
    logic                         ex_fwd;      // EX result usable this cycle
    mips_pkg::ctrl_t              ctrl;
    mips_pkg::data_t              ra_data;
    mips_pkg::data_t              rb_data;
    mips_pkg::data_t              imm_ext;

    // Instruction fields
    assign op      = i_if_id.instr[31:26];
    assign rs      = i_if_id.instr[25:21];
    assign rt      = i_if_id.instr[20:16];
    assign rd      = i_if_id.instr[15:11];
    assign funct   = i_if_id.instr[mips_pkg::NB_FUNCT-1:0];
    assign imm_ext = {{(mips_pkg::NB_DATA-mips_pkg::NB_IMM){i_if_id.instr[15]}},
                      i_if_id.instr[mips_pkg::NB_IMM-1:0]};

    // ----------------------------------------------------------
    // Register file
    // ----------------------------------------------------------
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**mips_pkg::NB_REG_ADDR; i++) begin
                reg_file[i] <= '0;
            end
        end else if (i_mem_wb.reg_write) begin
            reg_file[i_mem_wb.dst] <= i_mem_wb.data;   // r0 filtered at write back
        end
    end

    assign o_debug_read_reg = reg_file[i_debug_read_reg_address];

    // ----------------------------------------------------------
    // Decoder with unknown codes as nop
    // ----------------------------------------------------------
    always_comb begin
        ctrl = '0;
        if (i_if_id.valid) begin
            case (op)
                mips_pkg::OP_RTYPE: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.reg_dst   = 1'b1;
                    case (funct)
                        mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                        mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                        mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
                        mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
                        mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
                        default:           ctrl = '0;       // Includes all-zero word
                    endcase
                end
                mips_pkg::OP_ADDIU: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
                mips_pkg::OP_LW: begin
                    ctrl.reg_write  = 1'b1;
                    ctrl.mem_read   = 1'b1;
                    ctrl.mem_to_reg = 1'b1;
                    ctrl.alu_src    = 1'b1;
                end
                mips_pkg::OP_SW: begin
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                end
                default: ctrl = '0;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Forwarding where the nearest stage wins
    // ----------------------------------------------------------
    assign ex_dst = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;
    assign ex_fwd = i_id_ex.ctrl.reg_write && !i_id_ex.ctrl.mem_read;   // Load data not ready yet

    function automatic mips_pkg::data_t fwd_operand(input mips_pkg::reg_addr_t src,
                                                   input mips_pkg::data_t rf_data);
        mips_pkg::data_t val;
        val = rf_data;
        if (src == '0) begin
            val = '0;                                           // r0 always zero
        end else if (ex_fwd && ex_dst == src) begin
            val = i_ex_result;
        end else if (i_ex_mem.ctrl.reg_write && i_ex_mem.dst == src) begin
            val = i_mem_result;
        end else if (i_mem_wb.reg_write && i_mem_wb.dst == src) begin
            val = i_mem_wb.data;
        end
        return val;
    endfunction

    always_comb begin
        ra_data = fwd_operand(rs, reg_file[rs]);
        rb_data = fwd_operand(rt, reg_file[rt]);
    end

    assign o_id_ex_next = '{ctrl: ctrl, ra: ra_data, rb: rb_data, imm: imm_ext, rt: rt, rd: rd};

    // Load-use hazard when a load in EX feeds the instruction in decode
    assign o_stall = i_id_ex.ctrl.mem_read && (i_id_ex.rt != '0)
                  && ((i_id_ex.rt == rs) || (i_id_ex.rt == rt));

    // Stall only for a register-writing load ahead of a fetched instruction
    a_stall_on_load : assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_stall |-> (i_id_ex.ctrl.mem_read && i_id_ex.ctrl.reg_write && i_if_id.valid));

endmodule

`default_nettype wire

// ==== rtl/instruction_fetch.sv ====
`default_nettype none

module instruction_fetch (
    output mips_pkg::data_t  o_instruction               ,
    output mips_pkg::data_t  o_pc                        ,
    output logic             o_is_program_end            ,

    input  logic             i_load_program_write_enable ,
    input  mips_pkg::byte_t  i_load_program_byte         ,
    input  logic             i_stall                     ,
    input  logic             i_run                       ,
    input  logic             i_rst_n                     ,
    input  logic             i_clock
);

    localparam int NB_LOAD_CNT = mips_pkg::NB_PROG_ADDR + 3;   // Byte count up to 256

    mips_pkg::data_t         prog_mem [2**mips_pkg::NB_PROG_ADDR];
    logic [NB_LOAD_CNT-1:0]  load_cnt;      // Bytes loaded so far
    mips_pkg::data_t         pc;
    mips_pkg::data_t         end_pc;        // Byte address after last whole word
    logic                    at_end;

    // Byte loader, little endian within each word
    always_ff @(posedge i_clock) begin
        if (i_load_program_write_enable) begin
            prog_mem[load_cnt[NB_LOAD_CNT-2:2]][load_cnt[1:0]*mips_pkg::NB_BYTE +: mips_pkg::NB_BYTE]
                <= i_load_program_byte;
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            load_cnt <= '0;
        end else if (i_load_program_write_enable) begin
            load_cnt <= load_cnt + 1'b1;
        end
    end

    assign end_pc = mips_pkg::data_t'({load_cnt[NB_LOAD_CNT-1:2], 2'b00});
    assign at_end = (pc == end_pc);

    // PC holds on stall and once the program is exhausted
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            pc <= '0;
        end else if (i_run && !i_stall && !at_end) begin
            pc <= pc + 32'd4;
        end
    end

    assign o_instruction    = at_end ? '0 : prog_mem[pc[mips_pkg::NB_PROG_ADDR+1:2]];  // Nop past end
    assign o_pc             = pc;
    assign o_is_program_end = i_run && at_end;

    // Program memory is only written while the pipeline is frozen
    a_no_load_while_run : assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_load_program_write_enable |-> !i_run);

endmodule

`default_nettype wire

// ==== rtl/memory_access.sv ====
`default_nettype none

module memory_access (
    output mips_pkg::mem_wb_t  o_mem_wb_next ,
    output mips_pkg::data_t    o_mem_result  ,
    input  mips_pkg::ex_mem_t  i_ex_mem      ,
    input  logic               i_clock
);

    mips_pkg::data_t                  data_mem [2**mips_pkg::NB_DMEM_ADDR];
    logic [mips_pkg::NB_DMEM_ADDR-1:0] word_addr;     // Word index from byte address

    assign word_addr = i_ex_mem.alu_result[mips_pkg::NB_DMEM_ADDR+1:2];

    // Whole words only
    always_ff @(posedge i_clock) begin
        if (i_ex_mem.ctrl.mem_write) begin
            data_mem[word_addr] <= i_ex_mem.store_data;
        end
    end

    assign o_mem_result  = i_ex_mem.ctrl.mem_to_reg ? data_mem[word_addr] : i_ex_mem.alu_result;
    assign o_mem_wb_next = '{reg_write: i_ex_mem.ctrl.reg_write,
                             data:      o_mem_result,
                             dst:       i_ex_mem.dst};

    // Address must stay inside the 128 byte window
    a_addr_in_range : assert property (@(posedge i_clock)
        (i_ex_mem.ctrl.mem_read || i_ex_mem.ctrl.mem_write)
            |-> (i_ex_mem.alu_result >> (mips_pkg::NB_DMEM_ADDR + 2)) == '0);

endmodule

`default_nettype wire

// ==== rtl/mips.sv ====
`default_nettype none

module mips (
    output mips_pkg::data_t      o_debug_read_reg            ,
    output mips_pkg::data_t      o_debug_read_pc             ,
    output logic                 o_is_program_end            ,

    input  mips_pkg::reg_addr_t  i_debug_read_reg_address    ,
    input  mips_pkg::byte_t      i_load_program_byte         ,
    input  logic                 i_load_program_write_enable ,
    input  logic                 i_run                       ,
    input  logic                 i_rst_n                     ,
    input  logic                 i_clock
);

    mips_pkg::data_t    instruction;
    mips_pkg::if_id_t   if_id;
    mips_pkg::id_ex_t   id_ex;
    mips_pkg::id_ex_t   id_ex_next;
    mips_pkg::ex_mem_t  ex_mem;
    mips_pkg::ex_mem_t  ex_mem_next;
    mips_pkg::mem_wb_t  mem_wb;
    mips_pkg::mem_wb_t  mem_wb_next;
    mips_pkg::mem_wb_t  wb;             // Write back into register file
    mips_pkg::data_t    mem_result;
    logic               stall;

    // ----------------------------------------------------------
    // Fetch
    // ----------------------------------------------------------
    instruction_fetch u_instruction_fetch (
        .o_instruction               (instruction                 ),
        .o_pc                        (o_debug_read_pc             ),
        .o_is_program_end            (o_is_program_end            ),
        .i_load_program_write_enable (i_load_program_write_enable ),
        .i_load_program_byte         (i_load_program_byte         ),
        .i_stall                     (stall                       ),
        .i_run                       (i_run                       ),
        .i_rst_n                     (i_rst_n                     ),
        .i_clock                     (i_clock                     )
    );

    // IF/ID holds on stall and marks fetch past end as invalid
    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            if_id <= '0;
        end else if (i_run && !stall) begin
            if_id <= '{valid: !o_is_program_end, instr: instruction};
        end
    end

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    instruction_decode u_instruction_decode (
        .o_id_ex_next             (id_ex_next               ),
        .o_stall                  (stall                    ),
        .o_debug_read_reg         (o_debug_read_reg         ),
        .i_if_id                  (if_id                    ),
        .i_id_ex                  (id_ex                    ),
        .i_ex_result              (ex_mem_next.alu_result   ),
        .i_ex_mem                 (ex_mem                   ),
        .i_mem_result             (mem_result               ),
        .i_mem_wb                 (wb                       ),
        .i_debug_read_reg_address (i_debug_read_reg_address ),
        .i_rst_n                  (i_rst_n                  ),
        .i_clock                  (i_clock                  )
    );

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            id_ex <= '0;
        end else if (i_run) begin
            id_ex <= stall ? '0 : id_ex_next;      // Bubble behind a stalled load
        end
    end

    // ----------------------------------------------------------
    // Execute and memory
    // ----------------------------------------------------------
    execution u_execution (
        .o_ex_mem_next (ex_mem_next ),
        .i_id_ex       (id_ex       )
    );

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            ex_mem <= '0;
        end else if (i_run) begin
            ex_mem <= ex_mem_next;
        end
    end

    memory_access u_memory_access (
        .o_mem_wb_next (mem_wb_next ),
        .o_mem_result  (mem_result  ),
        .i_ex_mem      (ex_mem      ),
        .i_clock       (i_clock     )
    );

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            mem_wb <= '0;
        end else if (i_run) begin
            mem_wb <= mem_wb_next;
        end
    end

    // Write back drops writes to r0
    always_comb begin
        wb = mem_wb;
        if (mem_wb.dst == '0) begin
            wb.reg_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    // ----------------------------------------------------------
    // Widths and sizes
    // ----------------------------------------------------------
    localparam int NB_DATA      = 32;   // Data and address word
    localparam int NB_BYTE      = 8;    // Loader byte
    localparam int NB_REG_ADDR  = 5;    // 32 registers
    localparam int NB_PROG_ADDR = 6;    // 64 program words
    localparam int NB_DMEM_ADDR = 5;    // 32 data words
    localparam int NB_OP        = 6;
    localparam int NB_FUNCT     = 6;
    localparam int NB_IMM       = 16;   // I-type immediate field
    localparam int NB_ALU_OP    = 3;

    typedef logic [NB_DATA-1:0]     data_t;
    typedef logic [NB_REG_ADDR-1:0] reg_addr_t;
    typedef logic [NB_BYTE-1:0]     byte_t;
    typedef logic [NB_ALU_OP-1:0]   alu_op_t;

    // ----------------------------------------------------------
    // Opcode, function and ALU codes
    // ----------------------------------------------------------
    localparam logic [NB_OP-1:0] OP_RTYPE = 6'h00;
    localparam logic [NB_OP-1:0] OP_ADDIU = 6'h09;
    localparam logic [NB_OP-1:0] OP_LW    = 6'h23;
    localparam logic [NB_OP-1:0] OP_SW    = 6'h2b;

    localparam logic [NB_FUNCT-1:0] FN_ADDU = 6'h21;
    localparam logic [NB_FUNCT-1:0] FN_SUBU = 6'h23;
    localparam logic [NB_FUNCT-1:0] FN_AND  = 6'h24;
    localparam logic [NB_FUNCT-1:0] FN_OR   = 6'h25;
    localparam logic [NB_FUNCT-1:0] FN_SLT  = 6'h2a;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;    // Signed compare

    // ----------------------------------------------------------
    // Controls and pipeline registers
    // ----------------------------------------------------------
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;   // Write back load data
        logic    alu_src;      // Immediate as second operand
        logic    reg_dst;      // rd as destination, else rt
        alu_op_t alu_op;
    } ctrl_t;                  // 9 bits

    typedef struct packed {
        logic  valid;
        data_t instr;
    } if_id_t;                 // 33 bits

    typedef struct packed {
        ctrl_t     ctrl;
        data_t     ra;         // Forwarded rs value
        data_t     rb;         // Forwarded rt value
        data_t     imm;        // Sign extended
        reg_addr_t rt;
        reg_addr_t rd;
    } id_ex_t;                 // 115 bits

    typedef struct packed {
        ctrl_t     ctrl;
        data_t     alu_result;
        data_t     store_data;
        reg_addr_t dst;
    } ex_mem_t;                // 78 bits

    typedef struct packed {
        logic      reg_write;
        data_t     data;
        reg_addr_t dst;
    } mem_wb_t;                // 38 bits

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --assert --top-module mips_tb -f files.f \
    && ./obj_dir/Vmips_tb | grep "STATUS: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== sim/clock_gen.sv ====
`default_nettype none

module clock_gen #(
    parameter int PERIOD = 100          // Full clock period in time units
) (
    output logic o_clock
);

    // Free running, starts low
    initial begin
        o_clock = 1'b0;
        forever #(PERIOD / 2) o_clock = ~o_clock;
    end

endmodule

`default_nettype wire

// ==== sim/mips_tb.sv ====
`default_nettype none

module mips_tb;

    localparam int N_RUNS       = 8;
    localparam int N_INSTR      = 24;
    localparam int PROG_BYTES   = N_INSTR * 4;
    localparam int RESET_CYCLES = 2;
    localparam int DRAIN_CYCLES = 6;    // Pipeline empties after the end flag
    localparam int N_REGS       = 32;
    localparam int N_DWORDS     = 32;
    localparam int SEED         = 41231;
    // Worst case per run with one stall per instruction
    localparam int RUN_CYCLES   = RESET_CYCLES + PROG_BYTES + 2 * N_INSTR
                                + DRAIN_CYCLES + N_REGS + 8;
    localparam int CYCLE_LIMIT  = N_RUNS * RUN_CYCLES * 5 / 4;

    logic                clock;
    logic                rst_n;
    logic                run;
    logic                load_we;
    mips_pkg::byte_t     load_byte;
    mips_pkg::reg_addr_t dbg_addr;
    mips_pkg::data_t     dbg_reg;
    mips_pkg::data_t     dbg_pc;
    logic                program_end;

    mips_pkg::data_t     program_words [N_INSTR];
    mips_pkg::data_t     model_regs [N_REGS];
    mips_pkg::data_t     model_mem [N_DWORDS];   // Data memory survives reset
    logic                mem_known [N_DWORDS];   // Word written by an earlier store
    int                  cycle_count = 0;

    clock_gen #(.PERIOD(100)) u_clock_gen (.o_clock(clock));

    mips u_mips (
        .o_debug_read_reg            (dbg_reg     ),
        .o_debug_read_pc             (dbg_pc      ),
        .o_is_program_end            (program_end ),
        .i_debug_read_reg_address    (dbg_addr    ),
        .i_load_program_byte         (load_byte   ),
        .i_load_program_write_enable (load_we     ),
        .i_run                       (run         ),
        .i_rst_n                     (rst_n       ),
        .i_clock                     (clock       )
    );

    // Global watchdog
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the program never finished", cycle_count);
            $display("STATUS: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------
    task automatic check_data(input string name, input mips_pkg::data_t expected,
                              input mips_pkg::data_t actual);
        if (actual !== expected) begin
            $display("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "data compare failed");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %b actual %b", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "flag compare failed");
        end
    endtask

    // Instruction encodings
    function automatic mips_pkg::data_t rtype_word(input logic [5:0] funct,
            input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt,
            input mips_pkg::reg_addr_t rd);
        return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'b0, funct};
    endfunction

    function automatic mips_pkg::data_t itype_word(input logic [5:0] op,
            input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic write_model_reg(input mips_pkg::reg_addr_t dst, input mips_pkg::data_t val);
        if (dst != '0) begin
            model_regs[dst] = val;      // r0 stays zero
        end
    endtask

    // ----------------------------------------------------------
    // Random program and sequential reference model
    // ----------------------------------------------------------
    task automatic build_program();
        int                  kind;
        int                  start;
        logic                found;
        mips_pkg::reg_addr_t rs;
        mips_pkg::reg_addr_t rt;
        mips_pkg::reg_addr_t rd;
        logic [15:0]         imm;
        logic [4:0]          word;
        logic [5:0]          funct;
        mips_pkg::data_t     a;
        mips_pkg::data_t     b;
        mips_pkg::data_t     res;
        for (int i = 0; i < N_INSTR; i++) begin
            kind  = $urandom_range(0, 9);
            rs    = mips_pkg::reg_addr_t'($urandom_range(0, 7));    // Few registers give hazards
            rt    = mips_pkg::reg_addr_t'($urandom_range(0, 7));
            rd    = mips_pkg::reg_addr_t'($urandom_range(0, 7));
            imm   = 16'($urandom());
            word  = 5'($urandom_range(0, N_DWORDS - 1));
            a     = model_regs[rs];
            b     = model_regs[rt];
            found = 1'b0;
            if (kind >= 8) begin
                // Loads only read words that a store has defined
                start = $urandom_range(0, N_DWORDS - 1);
                for (int j = 0; j < N_DWORDS; j++) begin
                    if (!found && mem_known[(start + j) % N_DWORDS]) begin
                        word  = 5'((start + j) % N_DWORDS);
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    kind = 7;                                   // Store instead
                end
            end
            if (kind <= 4) begin
                case (kind)
                    0: begin funct = mips_pkg::FN_ADDU; res = a + b; end
                    1: begin funct = mips_pkg::FN_SUBU; res = a - b; end
                    2: begin funct = mips_pkg::FN_AND;  res = a & b; end
                    3: begin funct = mips_pkg::FN_OR;   res = a | b; end
                    default: begin
                        funct = mips_pkg::FN_SLT;
                        res   = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;   // Signed
                    end
                endcase
                program_words[i] = rtype_word(funct, rs, rt, rd);
                write_model_reg(rd, res);
            end else if (kind <= 6) begin
                program_words[i] = itype_word(mips_pkg::OP_ADDIU, rs, rt, imm);
                write_model_reg(rt, a + {{16{imm[15]}}, imm});
            end else if (kind == 7) begin
                program_words[i] = itype_word(mips_pkg::OP_SW, '0, rt, {9'b0, word, 2'b00});
                model_mem[word]  = b;
                mem_known[word]  = 1'b1;
            end else begin
                program_words[i] = itype_word(mips_pkg::OP_LW, '0, rt, {9'b0, word, 2'b00});
                write_model_reg(rt, model_mem[word]);
            end
        end
    endtask

    // ----------------------------------------------------------
    // DUT sequences driven on the falling edge
    // ----------------------------------------------------------
    task automatic reset_dut();
        @(negedge clock);
        run     = 1'b0;
        load_we = 1'b0;
        rst_n   = 1'b0;
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n   = 1'b1;
    endtask

    task automatic load_program();
        for (int w = 0; w < N_INSTR; w++) begin
            for (int k = 0; k < 4; k++) begin
                @(negedge clock);
                load_we   = 1'b1;
                load_byte = program_words[w][8 * k +: 8];   // Little endian
            end
        end
        @(negedge clock);
        load_we = 1'b0;
    endtask

    task automatic run_program(input int idx);
        run = 1'b1;
        while (!program_end) begin
            @(negedge clock);
        end
        check_data($sformatf("run %0d end pc", idx), mips_pkg::data_t'(PROG_BYTES), dbg_pc);
        repeat (DRAIN_CYCLES) @(negedge clock);
        check_flag($sformatf("run %0d end flag held", idx), 1'b1, program_end);
        run = 1'b0;                     // Freeze before reading registers
    endtask

    task automatic compare_registers(input int idx);
        for (int r = 0; r < N_REGS; r++) begin
            dbg_addr = mips_pkg::reg_addr_t'(r);
            @(negedge clock);
            check_data($sformatf("run %0d r%0d", idx, r), model_regs[r], dbg_reg);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        load_we   = 1'b0;
        load_byte = '0;
        dbg_addr  = '0;
        void'($urandom(SEED));
        for (int m = 0; m < N_DWORDS; m++) begin
            model_mem[m] = '0;
            mem_known[m] = 1'b0;
        end
        for (int t = 0; t < N_RUNS; t++) begin
            reset_dut();
            check_flag($sformatf("run %0d end flag after reset", t), 1'b0, program_end);
            for (int r = 0; r < N_REGS; r++) begin
                model_regs[r] = '0;     // Register file clears on reset
            end
            build_program();
            load_program();
            run_program(t);
            compare_registers(t);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
